// File: verilog/vga_pkg.sv
// shared types and colours for the vga pixel pipeline
package vga_pkg;

    // pixel and line counter width
    typedef logic [10:0] count_t;

    // pointer coordinate, as delivered by the mouse side
    typedef logic [11:0] pos_t;

    // 4:4:4 colour, red in the top nibble
    typedef logic [11:0] rgb_t;

    // one-pixel frame around the active area
    localparam rgb_t COLOR_BORDER = 12'hfff;

    // cursor fill
    localparam rgb_t COLOR_CURSOR = 12'hf00;

    // forced during horizontal and vertical blanking
    localparam rgb_t COLOR_BLANK  = 12'h000;

endpackage

// File: verilog/vga_timing.sv
`timescale 1ns/1ps

// horizontal and vertical counters with sync and blanking decode
module vga_timing import vga_pkg::*; #(
    parameter int H_ACTIVE = 800,
    parameter int H_FP     = 40,
    parameter int H_SYNC   = 128,
    parameter int H_BP     = 88,
    parameter int V_ACTIVE = 600,
    parameter int V_FP     = 1,
    parameter int V_SYNC   = 4,
    parameter int V_BP     = 23
) (
    input  logic   clk,
    input  logic   reset,
    output count_t hcount,
    output count_t vcount,
    output logic   hsync,
    output logic   vsync,
    output logic   hblnk,
    output logic   vblnk
);

    // last count of a line and of a frame
    localparam count_t H_LAST = count_t'(H_ACTIVE + H_FP + H_SYNC + H_BP - 1);
    localparam count_t V_LAST = count_t'(V_ACTIVE + V_FP + V_SYNC + V_BP - 1);

    // sync window, first count and first count past it
    localparam count_t H_SYNC_START = count_t'(H_ACTIVE + H_FP);
    localparam count_t H_SYNC_END   = count_t'(H_ACTIVE + H_FP + H_SYNC);
    localparam count_t V_SYNC_START = count_t'(V_ACTIVE + V_FP);
    localparam count_t V_SYNC_END   = count_t'(V_ACTIVE + V_FP + V_SYNC);

    // blanking starts right after the active area
    localparam count_t H_BLANK_START = count_t'(H_ACTIVE);
    localparam count_t V_BLANK_START = count_t'(V_ACTIVE);

    count_t hcount_nxt;
    count_t vcount_nxt;

    // counter advance, vcount steps on the line wrap
    always_comb begin
        hcount_nxt = hcount;
        vcount_nxt = vcount;
        if (hcount == H_LAST) begin
            hcount_nxt = '0;
            if (vcount == V_LAST) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = vcount + count_t'(1);
            end
        end else begin
            hcount_nxt = hcount + count_t'(1);
        end
    end

    // flags are decoded from the next counts so they line up
    // with the counter values they are registered next to
    always_ff @(posedge clk) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            // active high sync pulses
            hsync  <= (hcount_nxt >= H_SYNC_START) && (hcount_nxt < H_SYNC_END);
            vsync  <= (vcount_nxt >= V_SYNC_START) && (vcount_nxt < V_SYNC_END);
            // porches and sync all count as blanking
            hblnk  <= (hcount_nxt >= H_BLANK_START);
            vblnk  <= (vcount_nxt >= V_BLANK_START);
        end
    end

    // sync pulse sits inside the blanking interval
    a_hsync_in_hblnk: assert property (
        @(posedge clk) disable iff (reset) hsync |-> hblnk
    ) else $error("hsync high outside horizontal blanking");

    a_vsync_in_vblnk: assert property (
        @(posedge clk) disable iff (reset) vsync |-> vblnk
    ) else $error("vsync high outside vertical blanking");

endmodule

// File: verilog/draw_bg.sv
`timescale 1ns/1ps

// background stage, white border around a coloured gradient
module draw_bg import vga_pkg::*; #(
    parameter int H_ACTIVE = 800,
    parameter int V_ACTIVE = 600
) (
    input  logic   clk,
    input  logic   reset,
    input  count_t hcount_in,
    input  count_t vcount_in,
    input  logic   hsync_in,
    input  logic   vsync_in,
    input  logic   hblnk_in,
    input  logic   vblnk_in,
    output count_t hcount_out,
    output count_t vcount_out,
    output logic   hsync_out,
    output logic   vsync_out,
    output logic   hblnk_out,
    output logic   vblnk_out,
    output rgb_t   rgb_out
);

    // last active column and row
    localparam count_t H_EDGE = count_t'(H_ACTIVE - 1);
    localparam count_t V_EDGE = count_t'(V_ACTIVE - 1);

    // fixed blue nibble of the gradient
    localparam logic [3:0] GRAD_BLUE = 4'd8;

    rgb_t rgb_nxt;
    logic on_border;

    // first or last column or row of the active area
    assign on_border = (hcount_in == '0) || (hcount_in == H_EDGE) ||
                       (vcount_in == '0) || (vcount_in == V_EDGE);

    always_comb begin
        if (hblnk_in || vblnk_in) begin
            rgb_nxt = COLOR_BLANK;
        end else if (on_border) begin
            rgb_nxt = COLOR_BORDER;
        end else begin
            // red follows x, green follows y
            rgb_nxt = {hcount_in[7:4], vcount_in[7:4], GRAD_BLUE};
        end
    end

    // one stage of delay for colour and timing alike
    always_ff @(posedge clk) begin
        if (reset) begin
            hcount_out <= '0;
            vcount_out <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            hblnk_out  <= 1'b0;
            vblnk_out  <= 1'b0;
            rgb_out    <= COLOR_BLANK;
        end else begin
            hcount_out <= hcount_in;
            vcount_out <= vcount_in;
            hsync_out  <= hsync_in;
            vsync_out  <= vsync_in;
            hblnk_out  <= hblnk_in;
            vblnk_out  <= vblnk_in;
            rgb_out    <= rgb_nxt;
        end
    end

endmodule

// File: verilog/draw_mouse.sv
`timescale 1ns/1ps

// square cursor overlay, pointer position held for a whole frame
module draw_mouse import vga_pkg::*; #(
    parameter int CURSOR_SIZE = 8
) (
    input  logic   clk,
    input  logic   reset,
    input  pos_t   xpos,
    input  pos_t   ypos,
    input  count_t hcount_in,
    input  count_t vcount_in,
    input  logic   hsync_in,
    input  logic   vsync_in,
    input  logic   hblnk_in,
    input  logic   vblnk_in,
    input  rgb_t   rgb_in,
    output logic   hsync_out,
    output logic   vsync_out,
    output rgb_t   rgb_out
);

    // one spare bit so x + size cannot wrap
    localparam int EXT_W = $bits(pos_t) + 1;

    typedef logic [EXT_W-1:0] ext_t;

    typedef enum logic {
        WAIT_FRAME,
        TRACK
    } frame_state_t;

    frame_state_t state;
    frame_state_t state_nxt;

    pos_t xpos_q;
    pos_t ypos_q;
    pos_t x_cur;
    pos_t y_cur;

    // blanking of the pixel now on the outputs
    logic hblnk_q;
    logic vblnk_q;

    logic frame_start;
    logic draw_en;
    logic in_cursor;

    ext_t h_ext;
    ext_t v_ext;

    // (0, 0) right after a blanked pixel, so the zeros that
    // leave the previous stage during reset are not taken
    assign frame_start = (hcount_in == '0) && (vcount_in == '0) && vblnk_q;

    // the (0, 0) pixel already uses the freshly sampled position
    assign x_cur = frame_start ? xpos : xpos_q;
    assign y_cur = frame_start ? ypos : ypos_q;

    // nothing drawn before the first latch
    assign draw_en = (state == TRACK) || frame_start;

    assign h_ext = ext_t'(hcount_in);
    assign v_ext = ext_t'(vcount_in);

    // inside the square and outside blanking, which clips at the edge
    assign in_cursor = draw_en && !hblnk_in && !vblnk_in &&
                       (h_ext >= ext_t'(x_cur)) &&
                       (h_ext <  ext_t'(x_cur) + ext_t'(CURSOR_SIZE)) &&
                       (v_ext >= ext_t'(y_cur)) &&
                       (v_ext <  ext_t'(y_cur) + ext_t'(CURSOR_SIZE));

    always_comb begin
        state_nxt = state;
        case (state)
            WAIT_FRAME: begin
                if (frame_start) begin
                    state_nxt = TRACK;
                end
            end
            TRACK: begin
                state_nxt = TRACK;
            end
            default: begin
                state_nxt = WAIT_FRAME;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= WAIT_FRAME;
            xpos_q    <= '0;
            ypos_q    <= '0;
            hblnk_q   <= 1'b0;
            vblnk_q   <= 1'b0;
            hsync_out <= 1'b0;
            vsync_out <= 1'b0;
            rgb_out   <= COLOR_BLANK;
        end else begin
            state <= state_nxt;
            // position reload once per frame
            if (frame_start) begin
                xpos_q <= xpos;
                ypos_q <= ypos;
            end
            hblnk_q   <= hblnk_in;
            vblnk_q   <= vblnk_in;
            hsync_out <= hsync_in;
            vsync_out <= vsync_in;
            rgb_out   <= in_cursor ? COLOR_CURSOR : rgb_in;
        end
    end

    // background already blanks, the cursor must not undo it
    a_blank_black: assert property (
        @(posedge clk) disable iff (reset) (hblnk_q || vblnk_q) |-> (rgb_out == COLOR_BLANK)
    ) else $error("colour not black during blanking");

endmodule

// File: verilog/top_vga.sv
`timescale 1ns/1ps

// pipeline top, timing -> background -> cursor
module top_vga import vga_pkg::*; #(
    parameter int H_ACTIVE    = 800,
    parameter int H_FP        = 40,
    parameter int H_SYNC      = 128,
    parameter int H_BP        = 88,
    parameter int V_ACTIVE    = 600,
    parameter int V_FP        = 1,
    parameter int V_SYNC      = 4,
    parameter int V_BP        = 23,
    parameter int CURSOR_SIZE = 8
) (
    input  logic       clk,
    input  logic       reset,
    input  pos_t       xpos,
    input  pos_t       ypos,
    output logic       vs,
    output logic       hs,
    output logic [3:0] r,
    output logic [3:0] g,
    output logic [3:0] b
);

    // timing generator outputs
    count_t hcount_tim;
    count_t vcount_tim;
    logic   hsync_tim;
    logic   vsync_tim;
    logic   hblnk_tim;
    logic   vblnk_tim;

    // background stage outputs
    count_t hcount_bg;
    count_t vcount_bg;
    logic   hsync_bg;
    logic   vsync_bg;
    logic   hblnk_bg;
    logic   vblnk_bg;
    rgb_t   rgb_bg;

    // final colour
    rgb_t   rgb_mouse;

    assign {r, g, b} = rgb_mouse;

    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_ACTIVE (V_ACTIVE),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP)
    ) u_vga_timing (
        .clk    (clk),
        .reset  (reset),
        .hcount (hcount_tim),
        .vcount (vcount_tim),
        .hsync  (hsync_tim),
        .vsync  (vsync_tim),
        .hblnk  (hblnk_tim),
        .vblnk  (vblnk_tim)
    );

    draw_bg #(
        .H_ACTIVE (H_ACTIVE),
        .V_ACTIVE (V_ACTIVE)
    ) u_draw_bg (
        .clk        (clk),
        .reset      (reset),
        .hcount_in  (hcount_tim),
        .vcount_in  (vcount_tim),
        .hsync_in   (hsync_tim),
        .vsync_in   (vsync_tim),
        .hblnk_in   (hblnk_tim),
        .vblnk_in   (vblnk_tim),
        .hcount_out (hcount_bg),
        .vcount_out (vcount_bg),
        .hsync_out  (hsync_bg),
        .vsync_out  (vsync_bg),
        .hblnk_out  (hblnk_bg),
        .vblnk_out  (vblnk_bg),
        .rgb_out    (rgb_bg)
    );

    // pointer position arrives as plain levels
    draw_mouse #(
        .CURSOR_SIZE (CURSOR_SIZE)
    ) u_draw_mouse (
        .clk       (clk),
        .reset     (reset),
        .xpos      (xpos),
        .ypos      (ypos),
        .hcount_in (hcount_bg),
        .vcount_in (vcount_bg),
        .hsync_in  (hsync_bg),
        .vsync_in  (vsync_bg),
        .hblnk_in  (hblnk_bg),
        .vblnk_in  (vblnk_bg),
        .rgb_in    (rgb_bg),
        .hsync_out (hs),
        .vsync_out (vs),
        .rgb_out   (rgb_mouse)
    );

endmodule

// File: testbench/vga_ref.svh
`ifndef VGA_REF_SVH
`define VGA_REF_SVH

// reference model of one output pixel
// included inside top_vga_tb, uses its mode localparams

// expected colour at (h, v)
// show is set once a pointer position has been latched for the frame
function automatic rgb_t ref_rgb(
    input int h,
    input int v,
    input bit show,
    input int cx,
    input int cy
);
    bit blank;
    bit cursor;
    bit border;
    logic [3:0] red;
    logic [3:0] green;

    // porches and sync are all blanked
    blank = (h >= H_ACTIVE) || (v >= V_ACTIVE);

    // square of CURSOR_SIZE pixels from the latched corner
    cursor = show &&
             (h >= cx) && (h < cx + CURSOR_SIZE) &&
             (v >= cy) && (v < cy + CURSOR_SIZE);

    // one pixel frame on the outer active rows and columns
    border = (h == 0) || (h == H_ACTIVE - 1) ||
             (v == 0) || (v == V_ACTIVE - 1);

    // gradient nibbles, count bits 7 to 4
    red   = 4'(h >> 4);
    green = 4'(v >> 4);

    if (blank) begin
        return COLOR_BLANK;
    end else if (cursor) begin
        // cursor sits on top of border and gradient
        return COLOR_CURSOR;
    end else if (border) begin
        return COLOR_BORDER;
    end else begin
        return {red, green, 4'd8};
    end
endfunction

// expected {vs, hs} at (h, v), both active high
function automatic logic [1:0] ref_sync(input int h, input int v);
    bit hsync;
    bit vsync;

    hsync = (h >= H_ACTIVE + H_FP) && (h < H_ACTIVE + H_FP + H_SYNC);
    vsync = (v >= V_ACTIVE + V_FP) && (v < V_ACTIVE + V_FP + V_SYNC);
    return {vsync, hsync};
endfunction

`endif

// File: testbench/top_vga_tb.sv
`timescale 1ns/1ps

// testbench for the vga pipeline in a small display mode
module top_vga_tb import vga_pkg::*; ();

    // small mode of 80 x 56 counts per frame
    localparam int H_ACTIVE     = 64;
    localparam int H_FP         = 4;
    localparam int H_SYNC       = 8;
    localparam int H_BP         = 4;
    localparam int V_ACTIVE     = 48;
    localparam int V_FP         = 2;
    localparam int V_SYNC       = 3;
    localparam int V_BP         = 3;
    localparam int CURSOR_SIZE  = 8;
    localparam int H_TOTAL      = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL      = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int NUM_FRAMES   = 4;
    localparam int RESET_CYCLES = 8;
    // last output pixel of the last frame leaves two cycles late
    localparam int END_CYCLE    = NUM_FRAMES * FRAME_CYCLES + 2;
    localparam int TIMEOUT      = RESET_CYCLES + NUM_FRAMES * FRAME_CYCLES + 200;

    `include "vga_ref.svh"

    logic       clk;
    logic       reset;
    pos_t       xpos;
    pos_t       ypos;
    logic       vs;
    logic       hs;
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;

    int seed;
    int cycle_count = 0;
    int stim_cycles = 0;
    bit started = 1'b0;

    // model counters track the pixel the timing stage holds
    int mh = 0;
    int mv = 0;
    bit wrapped = 1'b0;

    // first pipeline slot holds the pixel in the background stage
    bit s1_valid = 1'b0;
    int s1_h = 0;
    int s1_v = 0;
    bit s1_frame_start = 1'b0;

    // second slot holds the pixel now on the dut outputs
    bit s2_valid = 1'b0;
    int s2_h = 0;
    int s2_v = 0;
    bit s2_show = 1'b0;
    int s2_cx = 0;
    int s2_cy = 0;

    // pointer position held for the current frame
    bit lat_show = 1'b0;
    int lat_x = 0;
    int lat_y = 0;

    rgb_t       exp_rgb;
    logic [1:0] exp_sync;

    top_vga #(
        .H_ACTIVE    (H_ACTIVE),
        .H_FP        (H_FP),
        .H_SYNC      (H_SYNC),
        .H_BP        (H_BP),
        .V_ACTIVE    (V_ACTIVE),
        .V_FP        (V_FP),
        .V_SYNC      (V_SYNC),
        .V_BP        (V_BP),
        .CURSOR_SIZE (CURSOR_SIZE)
    ) dut0 (
        .clk   (clk),
        .reset (reset),
        .xpos  (xpos),
        .ypos  (ypos),
        .vs    (vs),
        .hs    (hs),
        .r     (r),
        .g     (g),
        .b     (b)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    task automatic check_rgb(input rgb_t got, input rgb_t exp, input int h, input int v);
        if (got !== exp) begin
            $display("** Error at %0t ns: pixel (%0d, %0d) rgb %h, expected %h",
                     $time, h, v, got, exp);
            $display("Something failed");
            $fatal(1, "colour mismatch");
        end
    endtask

    task automatic check_sync(input logic [1:0] got, input logic [1:0] exp,
                              input int h, input int v);
        if (got !== exp) begin
            $display("** Error at %0t ns: pixel (%0d, %0d) vs/hs %b, expected %b",
                     $time, h, v, got, exp);
            $display("Something failed");
            $fatal(1, "sync mismatch");
        end
    endtask

    // wait n rising edges and drive 1 ns after the last
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
        stim_cycles += n;
    endtask

    // x up to 127 and y up to 63, so some land off screen
    task automatic move_random(input bit off_screen);
        int rnd_x;
        int rnd_y;
        rnd_x = $random(seed);
        rnd_y = $random(seed);
        if (off_screen) begin
            xpos = pos_t'(H_ACTIVE + (rnd_x & 63));
        end else begin
            xpos = pos_t'(rnd_x & 127);
        end
        ypos = pos_t'(rnd_y & 63);
    endtask

    // pipeline model shifted on every rising edge
    always @(posedge clk) begin
        started = 1'b1;
        // latch at (0, 0) of every frame but the first after reset
        if (s1_valid && s1_frame_start && !reset) begin
            lat_show = 1'b1;
            lat_x = int'(xpos);
            lat_y = int'(ypos);
        end
        s2_valid = s1_valid && !reset;
        s2_h = s1_h;
        s2_v = s1_v;
        s2_show = lat_show;
        s2_cx = lat_x;
        s2_cy = lat_y;
        s1_valid = !reset;
        s1_h = mh;
        s1_v = mv;
        s1_frame_start = (mh == 0) && (mv == 0) && wrapped;
        if (reset) begin
            mh = 0;
            mv = 0;
            wrapped = 1'b0;
            lat_show = 1'b0;
        end else if (mh == H_TOTAL - 1) begin
            mh = 0;
            if (mv == V_TOTAL - 1) begin
                mv = 0;
                wrapped = 1'b1;
            end else begin
                mv++;
            end
        end else begin
            mh++;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (started) begin
            if (s2_valid) begin
                exp_rgb = ref_rgb(s2_h, s2_v, s2_show, s2_cx, s2_cy);
                exp_sync = ref_sync(s2_h, s2_v);
            end else begin
                // reset and pipeline fill
                exp_rgb = COLOR_BLANK;
                exp_sync = 2'b00;
            end
            check_sync({vs, hs}, exp_sync, s2_h, s2_v);
            check_rgb({r, g, b}, exp_rgb, s2_h, s2_v);
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT) begin
            $display("Simulation timed out after %0d cycles", cycle_count);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        seed = 66420;
        reset = 1'b1;
        xpos = pos_t'(20);
        ypos = pos_t'(20);
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        // no cursor in frame 0 and frame 1 takes (20, 20)
        wait_cycles(FRAME_CYCLES + 2000);
        // move in mid frame 1 shows from frame 2 on and clips at both edges
        xpos = pos_t'(60);
        ypos = pos_t'(44);
        wait_cycles(FRAME_CYCLES);
        // only the last move in frame 2 reaches frame 3
        repeat (7) begin
            move_random(1'b0);
            wait_cycles(300);
        end
        move_random(1'b1);
        wait_cycles(1000);
        // moves in mid frame 3 leave this frame alone
        repeat (8) begin
            move_random(1'b0);
            wait_cycles(400);
        end
        wait_cycles(END_CYCLE - stim_cycles);
        $display("Everything OK");
        $finish;
    end

endmodule

// File: project.f
+incdir+testbench
verilog/vga_pkg.sv
verilog/vga_timing.sv
verilog/draw_bg.sv
verilog/draw_mouse.sv
verilog/top_vga.sv
testbench/top_vga_tb.sv

// File: run.sh
#!/bin/sh
# build and run the vga pipeline testbench with verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module top_vga_tb -f project.f > sim.log 2>&1 &&
    ./obj_dir/Vtop_vga_tb >> sim.log 2>&1 ||
    echo "build or simulation exited with an error" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Everything OK" sim.log || { echo "FAIL: no pass message"; exit 1; }
echo "PASS"
